// File: common/soc_pkg.sv
`default_nettype none

package soc_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  sel_t;
  typedef logic [3:0]  region_t;
  typedef logic [3:0]  exc_t;
  typedef logic [1:0]  tmr_idx_t;
  typedef logic [1:0]  tmr_off_t;

  // request from the processor, fanned out to all targets
  typedef struct packed {
    logic  cyc;
    logic  we;
    sel_t  sel;
    addr_t adr;
    data_t dat;
  } bus_req_t;

  typedef struct packed {
    logic  ack;
    data_t dat;
  } slave_rsp_t;

  // address bits 31..28
  localparam region_t REGION_VECT  = 4'h0;
  localparam region_t REGION_TIMER = 4'h1;

  // chipselect codes, 0 means no target
  localparam region_t CS_NONE  = 4'h0;
  localparam region_t CS_VECT  = 4'h1;
  localparam region_t CS_TIMER = 4'h2;

  localparam exc_t EXC_RESET  = 4'h0;
  localparam exc_t EXC_MMU    = 4'h1;
  localparam exc_t EXC_TIMER0 = 4'h2;
  localparam exc_t EXC_TIMER1 = 4'h3;
  localparam exc_t EXC_TIMER2 = 4'h4;
  localparam exc_t EXC_TIMER3 = 4'h5;

  // timer registers, address bits 3..2
  localparam tmr_off_t TMR_COUNT   = 2'd0;
  localparam tmr_off_t TMR_COMPARE = 2'd1;
  localparam tmr_off_t TMR_CTRL    = 2'd2;

  localparam int CTRL_EN_BIT   = 0;
  localparam int CTRL_CLR_BIT  = 1;
  localparam int CTRL_FLAG_BIT = 8;

  // byte-enabled update of a stored word
  function automatic data_t merge_bytes(data_t old_w, data_t new_w, sel_t sel);
    data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++)
      if (sel[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    return res;
  endfunction

endpackage

`default_nettype wire

// File: design/mmu.sv
`timescale 1ns/1ns
`default_nettype none

module mmu
  import soc_pkg::*;
#(
  parameter int NUM_TIMERS = 4
)
(
  input  bus_req_t              bus_req_i,
  input  logic                  supervisor_i,
  output region_t               chipselect_o,
  output logic                  vect_stb_o,
  output logic [NUM_TIMERS-1:0] timer_stb_o,
  output logic                  fault_o
);

  region_t  region;
  tmr_idx_t tmr_idx;
  logic     vect_hit;
  logic     timer_hit;
  logic     bad_write;
  logic     bad_index;

  assign region  = bus_req_i.adr[31:28];
  assign tmr_idx = bus_req_i.adr[5:4];

  assign vect_hit  = (region == REGION_VECT);
  assign timer_hit = (region == REGION_TIMER);

  // vector table is writable from supervisor mode only
  assign bad_write = vect_hit & bus_req_i.we & ~supervisor_i;
  assign bad_index = timer_hit & (int'(tmr_idx) >= NUM_TIMERS);

  assign fault_o = bus_req_i.cyc & (~(vect_hit | timer_hit) | bad_write | bad_index);

  always_comb
  begin
    chipselect_o = CS_NONE;
    vect_stb_o   = 1'b0;
    timer_stb_o  = '0;
    // faulting accesses reach no target
    if (bus_req_i.cyc && !fault_o)
    begin
      if (vect_hit)
      begin
        chipselect_o = CS_VECT;
        vect_stb_o   = 1'b1;
      end
      else if (timer_hit)
      begin
        chipselect_o = CS_TIMER;
        for (int k = 0; k < NUM_TIMERS; k++)
          timer_stb_o[k] = (int'(tmr_idx) == k);
      end
    end
  end

endmodule

`default_nettype wire

// File: design/vector_ram.sv
`timescale 1ns/1ns
`default_nettype none

module vector_ram
  import soc_pkg::*;
(
  input  logic       sysclock,
  input  logic       rst_i,
  input  bus_req_t   bus_req_i,
  input  logic       stb_i,
  output slave_rsp_t rsp_o
);

  localparam int DEPTH = 32;

  data_t      mem [DEPTH];
  data_t      rd_q;
  logic [1:0] ack_sr;
  logic [4:0] idx;
  logic       go;
  logic       start;

  assign idx = bus_req_i.adr[6:2];
  assign go  = stb_i & bus_req_i.cyc;

  // first cycle of an access, pipeline still empty
  assign start = go & ~ack_sr[0] & ~ack_sr[1];

  // ack on the second cycle, cleared once the table is deselected
  always_ff @(posedge sysclock or posedge rst_i)
  begin
    if (rst_i)
      ack_sr <= 2'b00;
    else if (!go)
      ack_sr <= 2'b00;
    else
      ack_sr <= {ack_sr[0], start};
  end

  always_ff @(posedge sysclock)
  begin
    if (start && bus_req_i.we)
      mem[idx] <= merge_bytes(mem[idx], bus_req_i.dat, bus_req_i.sel);
    if (start)
      rd_q <= mem[idx];
  end

  assign rsp_o.ack = ack_sr[1];
  assign rsp_o.dat = rd_q;

endmodule

`default_nettype wire

// File: timer/timer_unit.sv
`timescale 1ns/1ns
`default_nettype none

module timer_unit
  import soc_pkg::*;
(
  input  logic       sysclock,
  input  logic       rst_i,
  input  bus_req_t   bus_req_i,
  input  logic       stb_i,
  output slave_rsp_t rsp_o,
  output logic       irq_o
);

  data_t    count_q;
  data_t    compare_q;
  data_t    dat_q;
  data_t    rd_word;
  logic     enable_q;
  logic     flag_q;
  logic     ack_q;
  logic     access;
  logic     wr;
  logic     hit;
  logic     clr_flag;
  tmr_off_t off;

  assign off    = bus_req_i.adr[3:2];
  assign access = stb_i & bus_req_i.cyc & ~ack_q;
  assign wr     = access & bus_req_i.we;
  assign hit    = (count_q == compare_q);

  // write 1 to ctrl bit 1 clears the flag
  assign clr_flag = wr & (off == TMR_CTRL) & bus_req_i.sel[0] & bus_req_i.dat[CTRL_CLR_BIT];

  always_ff @(posedge sysclock or posedge rst_i)
  begin
    if (rst_i)
    begin
      count_q <= '0;
      flag_q  <= 1'b0;
    end
    else
    begin
      if (enable_q)
        count_q <= hit ? '0 : count_q + 1'b1;
      if (clr_flag)
        flag_q <= 1'b0;
      // a match in the same cycle wins over the clear
      if (enable_q && hit)
        flag_q <= 1'b1;
    end
  end

  always_ff @(posedge sysclock or posedge rst_i)
  begin
    if (rst_i)
    begin
      compare_q <= '0;
      enable_q  <= 1'b0;
    end
    else if (wr)
    begin
      case (off)
        TMR_COMPARE: compare_q <= merge_bytes(compare_q, bus_req_i.dat, bus_req_i.sel);
        TMR_CTRL:
        begin
          if (bus_req_i.sel[0])
            enable_q <= bus_req_i.dat[CTRL_EN_BIT];
        end
        default: ;
      endcase
    end
  end

  always_comb
  begin
    rd_word = '0;
    case (off)
      TMR_COUNT:   rd_word = count_q;
      TMR_COMPARE: rd_word = compare_q;
      TMR_CTRL:
      begin
        rd_word[CTRL_EN_BIT]   = enable_q;
        rd_word[CTRL_FLAG_BIT] = flag_q;
      end
      default:     rd_word = '0;
    endcase
  end

  // single ack pulse one cycle after the strobe
  always_ff @(posedge sysclock or posedge rst_i)
  begin
    if (rst_i)
      ack_q <= 1'b0;
    else
      ack_q <= access;
  end

  always_ff @(posedge sysclock)
  begin
    if (access)
      dat_q <= rd_word;
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.dat = dat_q;
  assign irq_o     = flag_q;

endmodule

`default_nettype wire

// File: design/bus_return.sv
`timescale 1ns/1ns
`default_nettype none

module bus_return
  import soc_pkg::*;
#(
  parameter int NUM_TIMERS = 4
)
(
  input  logic                  sysclock,
  input  logic                  rst_i,
  input  bus_req_t              bus_req_i,
  input  region_t               chipselect_i,
  input  logic                  fault_i,
  input  slave_rsp_t            vect_rsp_i,
  input  slave_rsp_t            timer_rsp_i [NUM_TIMERS],
  input  logic [NUM_TIMERS-1:0] timer_irq_i,
  input  logic                  int_en_i,
  output data_t                 bus_dat_o,
  output logic                  bus_ack_o,
  output exc_t                  cpu_interrupt_o
);

  logic       fault_ack_q;
  logic       timer_ack;
  data_t      timer_dat;
  logic [3:0] irq_all;

  // terminate faulting accesses with a single ack
  always_ff @(posedge sysclock or posedge rst_i)
  begin
    if (rst_i)
      fault_ack_q <= 1'b0;
    else
      fault_ack_q <= fault_i & ~fault_ack_q;
  end

  // only the addressed timer acks
  always_comb
  begin
    timer_dat = '0;
    timer_ack = 1'b0;
    for (int k = 0; k < NUM_TIMERS; k++)
    begin
      if (timer_rsp_i[k].ack)
      begin
        timer_dat = timer_dat | timer_rsp_i[k].dat;
        timer_ack = 1'b1;
      end
    end
  end

  assign bus_dat_o = ((chipselect_i == CS_VECT)  ? vect_rsp_i.dat : '0) |
                     ((chipselect_i == CS_TIMER) ? timer_dat      : '0);

  assign bus_ack_o = bus_req_i.cyc &
                     (((chipselect_i == CS_VECT)  & vect_rsp_i.ack) |
                      ((chipselect_i == CS_TIMER) & timer_ack) |
                      fault_ack_q);

  assign irq_all = 4'(timer_irq_i);

  // priority: fault, then timer 3 down to timer 0
  always_comb
  begin
    cpu_interrupt_o = EXC_RESET;
    if (int_en_i)
    begin
      for (int k = 0; k < 4; k++)
        if (irq_all[k])
          cpu_interrupt_o = exc_t'(int'(EXC_TIMER0) + k);
      if (fault_i)
        cpu_interrupt_o = EXC_MMU;
    end
  end

endmodule

`default_nettype wire

// File: design/soc_fabric.sv
`timescale 1ns/1ns
`default_nettype none

module soc_fabric
  import soc_pkg::*;
#(
  parameter int NUM_TIMERS = 4
)
(
  input  logic     sysclock,
  input  logic     rst_i,
  input  bus_req_t bus_req_i,
  input  logic     supervisor_i,
  input  logic     int_en_i,
  output data_t    bus_dat_o,
  output logic     bus_ack_o,
  output logic     mmu_fault_o,
  output exc_t     cpu_interrupt_o
);

  region_t               chipselect;
  logic                  vect_stb;
  logic                  mmu_fault;
  logic [NUM_TIMERS-1:0] timer_stb;
  logic [NUM_TIMERS-1:0] timer_irq;
  slave_rsp_t            vect_rsp;
  slave_rsp_t            timer_rsp [NUM_TIMERS];

  mmu #(
    .NUM_TIMERS (NUM_TIMERS)
  ) i_mmu (
    .bus_req_i    (bus_req_i),
    .supervisor_i (supervisor_i),
    .chipselect_o (chipselect),
    .vect_stb_o   (vect_stb),
    .timer_stb_o  (timer_stb),
    .fault_o      (mmu_fault)
  );

  vector_ram i_vector_ram (
    .sysclock  (sysclock),
    .rst_i     (rst_i),
    .bus_req_i (bus_req_i),
    .stb_i     (vect_stb),
    .rsp_o     (vect_rsp)
  );

  // one timer per strobe bit
  for (genvar g = 0; g < NUM_TIMERS; g++)
  begin : g_timer
    timer_unit i_timer (
      .sysclock  (sysclock),
      .rst_i     (rst_i),
      .bus_req_i (bus_req_i),
      .stb_i     (timer_stb[g]),
      .rsp_o     (timer_rsp[g]),
      .irq_o     (timer_irq[g])
    );
  end

  bus_return #(
    .NUM_TIMERS (NUM_TIMERS)
  ) i_bus_return (
    .sysclock        (sysclock),
    .rst_i           (rst_i),
    .bus_req_i       (bus_req_i),
    .chipselect_i    (chipselect),
    .fault_i         (mmu_fault),
    .vect_rsp_i      (vect_rsp),
    .timer_rsp_i     (timer_rsp),
    .timer_irq_i     (timer_irq),
    .int_en_i        (int_en_i),
    .bus_dat_o       (bus_dat_o),
    .bus_ack_o       (bus_ack_o),
    .cpu_interrupt_o (cpu_interrupt_o)
  );

  assign mmu_fault_o = mmu_fault;

endmodule

`default_nettype wire

// File: tb/soc_fabric_checker.sv
`timescale 1ns/1ns
`default_nettype none

module soc_fabric_checker
  import soc_pkg::*;
#(
  parameter int NUM_TIMERS = 4
)
(
  input logic                  sysclock,
  input logic                  rst_i,
  input logic                  bus_ack_i,
  input logic                  fault_i,
  input logic                  vect_stb_i,
  input logic [NUM_TIMERS-1:0] timer_stb_i,
  input logic                  int_en_i,
  input exc_t                  cpu_interrupt_i
);

  // ack is a single-cycle pulse
  ack_pulse: assert property (@(posedge sysclock) disable iff (rst_i)
    bus_ack_i |=> !bus_ack_i)
    else $error("bus ack high for two consecutive cycles");

  // faulting accesses reach no target
  fault_no_stb: assert property (@(posedge sysclock) disable iff (rst_i)
    fault_i |-> !(vect_stb_i || (|timer_stb_i)))
    else $error("target strobe asserted during an MMU fault");

  int_masked: assert property (@(posedge sysclock) disable iff (rst_i)
    !int_en_i |-> (cpu_interrupt_i == EXC_RESET))
    else $error("interrupt code not EXC_RESET while interrupts are disabled");

endmodule

bind soc_fabric soc_fabric_checker #(
  .NUM_TIMERS (NUM_TIMERS)
) i_soc_fabric_checker (
  .sysclock        (sysclock),
  .rst_i           (rst_i),
  .bus_ack_i       (bus_ack_o),
  .fault_i         (mmu_fault),
  .vect_stb_i      (vect_stb),
  .timer_stb_i     (timer_stb),
  .int_en_i        (int_en_i),
  .cpu_interrupt_i (cpu_interrupt_o)
);

`default_nettype wire

// File: tb/soc_fabric_tb.sv
`timescale 1ns/1ns
`default_nettype none

module soc_fabric_tb
  import soc_pkg::*;
();

  // three timers, so that index 3 is out of range
  localparam int N_TMR    = 3;
  localparam int MAX_WAIT = 20;

  logic        sysclock;
  logic        rst_i;
  bus_req_t    req;
  logic        supervisor;
  logic        int_en;
  data_t       bus_dat;
  logic        bus_ack;
  logic        mmu_fault;
  exc_t        cpu_int;
  logic [31:0] lfsr_state = 32'hcfdffcc8;
  data_t       shadow [32];
  int          value_errors = 0;
  int          timeout_errors = 0;
  data_t       got_q [$];
  data_t       exp_q [$];
  string       msg_q [$];

  soc_fabric #(
    .NUM_TIMERS (N_TMR)
  ) i_soc_fabric (
    .sysclock        (sysclock),
    .rst_i           (rst_i),
    .bus_req_i       (req),
    .supervisor_i    (supervisor),
    .int_en_i        (int_en),
    .bus_dat_o       (bus_dat),
    .bus_ack_o       (bus_ack),
    .mmu_fault_o     (mmu_fault),
    .cpu_interrupt_o (cpu_int)
  );

  initial
  begin
    sysclock = 1'b0;
    forever #50 sysclock = ~sysclock;
  end

  // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic data_t rand_bits(int n);
    data_t v;
    logic  fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic data_t apply_sel(data_t old_w, data_t new_w, sel_t sel);
    data_t mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic ref_fault(addr_t adr, logic we, logic sup);
    if (adr[31:28] == 4'h0)
      return we && !sup;
    if (adr[31:28] == 4'h1)
      return adr[5:4] >= N_TMR;
    return 1'b1;
  endfunction

  function automatic int ref_latency(addr_t adr, logic faulting);
    if (faulting)
      return 1;
    return (adr[31:28] == 4'h0) ? 2 : 1;
  endfunction

  // fault first, then the highest-numbered flagged timer
  function automatic exc_t ref_exc(logic [3:0] flags, logic fault, logic en);
    if (!en)
      return EXC_RESET;
    if (fault)
      return EXC_MMU;
    for (int k = 3; k >= 0; k--)
      if (flags[k])
        return exc_t'(2 + k);
    return EXC_RESET;
  endfunction

  function automatic addr_t timer_addr(int k, tmr_off_t off);
    return 32'h1000_0000 | (addr_t'(k) << 4) | (addr_t'(off) << 2);
  endfunction

  task automatic check_value(data_t got, data_t exp, string msg);
    if (got !== exp)
    begin
      $display("FAIL %0t ns: %s (got %h, expected %h)", $time, msg, got, exp);
      value_errors++;
    end
  endtask

  function automatic void expect_value(data_t got, data_t exp, string msg);
    got_q.push_back(got);
    exp_q.push_back(exp);
    msg_q.push_back(msg);
  endfunction

  always @(negedge sysclock)
    while (got_q.size() > 0)
      check_value(got_q.pop_front(), exp_q.pop_front(), msg_q.pop_front());

  // one request, held until ack is seen, then cyc low for a cycle
  task automatic bus_access(addr_t adr, logic we, data_t wdat, sel_t sel, output data_t rdat);
    int   lat;
    logic flt;
    flt = ref_fault(adr, we, supervisor);
    @(negedge sysclock);
    req.cyc = 1'b1;
    req.we  = we;
    req.sel = sel;
    req.adr = adr;
    req.dat = wdat;
    lat = 0;
    do
    begin
      @(negedge sysclock);
      lat++;
    end
    while (!bus_ack && lat < MAX_WAIT);
    if (!bus_ack)
    begin
      $display("timeout: no bus acknowledge for address %h at %0t ns", adr, $time);
      timeout_errors++;
    end
    expect_value(lat, ref_latency(adr, flt), $sformatf("ack latency at %h", adr));
    expect_value(mmu_fault, flt, $sformatf("mmu fault at %h", adr));
    if (flt)
    begin
      expect_value(bus_dat, '0, $sformatf("fault data at %h", adr));
      expect_value(cpu_int, ref_exc(4'b0, 1'b1, int_en), "interrupt code on fault");
    end
    rdat = bus_dat;
    @(negedge sysclock);
    req.cyc = 1'b0;
    req.we  = 1'b0;
  endtask

  task automatic verify_vectors();
    data_t rd;
    for (int i = 0; i < 32; i++)
    begin
      bus_access(addr_t'(i * 4), 1'b0, '0, 4'hf, rd);
      expect_value(rd, shadow[i], $sformatf("vector entry %0d", i));
    end
  endtask

  task automatic check_code(logic [3:0] flags);
    int_en = 1'b1;
    @(negedge sysclock);
    expect_value(cpu_int, ref_exc(flags, 1'b0, 1'b1), "interrupt priority");
    int_en = 1'b0;
    @(negedge sysclock);
    expect_value(cpu_int, ref_exc(flags, 1'b0, 1'b0), "interrupt code with int_en low");
    int_en = 1'b1;
  endtask

  initial
  begin
    data_t      rd;
    data_t      d;
    data_t      cmp;
    sel_t       s;
    int         polls;
    logic [3:0] flags;
    int         clear_order [3];
    clear_order = '{1, 2, 0};
    req        = '0;
    supervisor = 1'b0;
    int_en     = 1'b0;
    rst_i      = 1'b1;
    repeat (2) @(negedge sysclock);
    rst_i  = 1'b0;
    int_en = 1'b1;
    @(negedge sysclock);
    expect_value(bus_ack, 1'b0, "ack after reset");
    expect_value(cpu_int, EXC_RESET, "interrupt code after reset");
    for (int k = 0; k < N_TMR; k++)
      repeat (3)
      begin
        bus_access(timer_addr(k, TMR_COUNT), 1'b0, '0, 4'hf, rd);
        expect_value(rd, '0, "count of disabled timer");
      end

    // supervisor fills the table, then random byte enables
    supervisor = 1'b1;
    for (int i = 0; i < 32; i++)
    begin
      d = rand_bits(32);
      bus_access(addr_t'(i * 4), 1'b1, d, 4'hf, rd);
      shadow[i] = d;
    end
    for (int i = 0; i < 32; i++)
    begin
      d = rand_bits(32);
      s = sel_t'(rand_bits(4));
      bus_access(addr_t'(i * 4), 1'b1, d, s, rd);
      shadow[i] = apply_sel(shadow[i], d, s);
    end
    verify_vectors();

    supervisor = 1'b0;
    for (int i = 0; i < 32; i += 5)
      bus_access(addr_t'(i * 4), 1'b1, rand_bits(32), 4'hf, rd);
    bus_access(32'h5000_0010, 1'b0, '0, 4'hf, rd);
    bus_access(32'hf000_0000, 1'b1, 32'hdead_beef, 4'hf, rd);
    bus_access(timer_addr(3, TMR_COUNT), 1'b0, '0, 4'hf, rd);
    supervisor = 1'b1;
    verify_vectors();

    for (int k = 0; k < N_TMR; k++)
    begin
      cmp = 4 + rand_bits(4);
      bus_access(timer_addr(k, TMR_COMPARE), 1'b1, cmp, 4'hf, rd);
      bus_access(timer_addr(k, TMR_COMPARE), 1'b0, '0, 4'hf, rd);
      expect_value(rd, cmp, "compare readback");
      bus_access(timer_addr(k, TMR_CTRL), 1'b1, 32'h1, 4'hf, rd);
      polls = 0;
      rd = '0;
      while (!rd[CTRL_FLAG_BIT] && polls < 40)
      begin
        bus_access(timer_addr(k, TMR_COUNT), 1'b0, '0, 4'hf, rd);
        expect_value(rd <= cmp, 1'b1, $sformatf("timer %0d count within compare", k));
        bus_access(timer_addr(k, TMR_CTRL), 1'b0, '0, 4'hf, rd);
        expect_value(rd[CTRL_EN_BIT], 1'b1, "enable bit readback");
        polls++;
      end
      if (!rd[CTRL_FLAG_BIT])
      begin
        $display("timeout: timer %0d flag never set at %0t ns", k, $time);
        timeout_errors++;
      end
      // stop the timer, the flag stays set
      bus_access(timer_addr(k, TMR_CTRL), 1'b1, 32'h0, 4'hf, rd);
    end

    flags = 4'((1 << N_TMR) - 1);
    check_code(flags);
    foreach (clear_order[j])
    begin
      bus_access(timer_addr(clear_order[j], TMR_CTRL), 1'b1, 32'h2, 4'hf, rd);
      flags[clear_order[j]] = 1'b0;
      check_code(flags);
    end

    repeat (2) @(negedge sysclock);
    @(posedge sysclock);
    $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
common/soc_pkg.sv
design/mmu.sv
design/vector_ram.sv
timer/timer_unit.sv
design/bus_return.sv
design/soc_fabric.sv
tb/soc_fabric_checker.sv
tb/soc_fabric_tb.sv
